/* rtl/frame_geom_pkg.sv */
// Frame geometry defaults and counter widths
// for the DMA frame readout path
package frame_geom_pkg;

	// Default frame size, 720p
	localparam int DEF_H_NUM = 1280;
	localparam int DEF_V_NUM = 720;

	// 1280x720 in BGRX needs 230400 words
	localparam int WORD_CNT_W = 18;

	// Colour-bar coordinates
	localparam int X_CNT_W = 9;     // Up to 320 words per line
	localparam int Y_CNT_W = 10;    // Up to 1024 lines

	// Read fsync toward the frame buffer
	localparam int FSYNC_STRETCH = 31;
	localparam int FSYNC_CNT_W   = 6;

endpackage

/* rtl/pixel_fmt_pkg.sv */
// Pixel and bus word types, colour-bar palette
// and RGB565 to BGRX expansion functions
package pixel_fmt_pkg;

	// BGR565 pixel, red in the low bits
	typedef struct packed {
		logic [4:0] b;
		logic [5:0] g;
		logic [4:0] r;
	} pix565_t;

	// 32-bit host pixel
	typedef struct packed {
		logic [7:0] x;    // Fixed pad byte
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} bgrx_t;

	typedef logic [127:0] bus_word_t;

	localparam logic [7:0] BGRX_PAD = 8'h08;

	// Bar palette, left to right
	localparam pix565_t BAR_RED     = 16'h001F;
	localparam pix565_t BAR_GREEN   = 16'h07E0;
	localparam pix565_t BAR_BLUE    = 16'hF800;
	localparam pix565_t BAR_YELLOW  = 16'h07FF;
	localparam pix565_t BAR_CYAN    = 16'hFFE0;
	localparam pix565_t BAR_MAGENTA = 16'hF81F;
	localparam pix565_t BAR_WHITE   = 16'hFFFF;
	localparam pix565_t BAR_BLACK   = 16'h0000;

	// Widen each field by repeating its top bits
	function automatic bgrx_t expand_565_to_bgrx(input pix565_t pix);
		bgrx_t px;
		px.x = BGRX_PAD;
		px.r = {pix.r, pix.r[4:2]};
		px.g = {pix.g, pix.g[5:4]};
		px.b = {pix.b, pix.b[4:2]};
		return px;
	endfunction

	function automatic bus_word_t pack_4pix_bgrx(input pix565_t p0, input pix565_t p1,
		input pix565_t p2, input pix565_t p3);
		return {expand_565_to_bgrx(p3), expand_565_to_bgrx(p2),
			expand_565_to_bgrx(p1), expand_565_to_bgrx(p0)};    // p0 in bits 31:0
	endfunction

endpackage

/* rtl/dma_frame_session.sv */
// Read session tracker with fsync stretch,
// BGRX expansion phase and MSI request
`timescale 1ns/1ps

module dma_frame_session #(
	parameter int H_NUM = frame_geom_pkg::DEF_H_NUM,
	parameter int V_NUM = frame_geom_pkg::DEF_V_NUM
) (
	input  logic pclk_div2,
	input  logic core_rst_n,
	input  logic i_mwr_cmd_start,    // DMA restart pulse
	input  logic i_frame_done,       // DMA end of frame pulse
	input  logic i_mwr_rd_clk_en,    // One word consumed
	input  logic i_bgrx_en,
	input  logic i_msi_en,
	input  logic i_msi_grant,
	output logic o_session_active,
	output logic o_session_start,
	output logic o_expand_phase,
	output logic o_rd_fsync,
	output logic o_msi_req
);
	import frame_geom_pkg::*;

	// Last word index of a frame with 8 or 4 pixels per word
	localparam logic [WORD_CNT_W-1:0] LAST_565  = WORD_CNT_W'(H_NUM * V_NUM / 8 - 1);
	localparam logic [WORD_CNT_W-1:0] LAST_BGRX = WORD_CNT_W'(H_NUM * V_NUM / 4 - 1);

	logic                   session_active;
	logic [WORD_CNT_W-1:0]  word_cnt;
	logic [WORD_CNT_W-1:0]  last_word;
	logic [FSYNC_CNT_W-1:0] fsync_cnt;
	logic                   expand_phase;
	logic                   msi_pending;
	logic                   word_taken;

	assign o_session_start = i_mwr_cmd_start & ~session_active;    // Ignored mid-session
	assign last_word = i_bgrx_en ? LAST_BGRX : LAST_565;
	assign word_taken = session_active & i_mwr_rd_clk_en;

	// ==================================================
	// Session, word count, fsync, phase
	// ==================================================
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			session_active <= 1'b0;
			word_cnt       <= '0;
			fsync_cnt      <= '0;
			expand_phase   <= 1'b0;
		end else if (i_frame_done) begin
			session_active <= 1'b0;
			word_cnt       <= '0;
			fsync_cnt      <= '0;
			expand_phase   <= 1'b0;
		end else if (o_session_start) begin
			session_active <= 1'b1;
			word_cnt       <= '0;
			fsync_cnt      <= FSYNC_CNT_W'(FSYNC_STRETCH);
			expand_phase   <= 1'b0;
		end else begin
			if (word_taken) begin
				if (word_cnt == last_word) begin
					word_cnt       <= '0;
					session_active <= 1'b0;    // Whole frame consumed
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
			// Two output words per fetched frame word
			if (word_taken && i_bgrx_en)
				expand_phase <= ~expand_phase;
			if (fsync_cnt != '0)
				fsync_cnt <= fsync_cnt - 1'b1;
		end
	end

	// A new frame end beats the grant
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			msi_pending <= 1'b0;
		else if (i_frame_done)
			msi_pending <= 1'b1;
		else if (i_msi_grant)
			msi_pending <= 1'b0;
	end

	assign o_session_active = session_active;
	assign o_expand_phase   = expand_phase;
	assign o_rd_fsync       = (fsync_cnt != '0);
	assign o_msi_req        = msi_pending & i_msi_en;

	// Mode is held for the whole session, so 565 never sees a half word
	a_phase_565: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		!i_bgrx_en |-> !expand_phase)
		else $error("Expansion phase set in 565 mode");

	// A request rises only after a frame end or when MSI gets enabled
	a_msi_en: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		$rose(o_msi_req) |-> $past(i_frame_done) || $rose(i_msi_en))
		else $error("MSI request raised without a frame end");

endmodule

/* rtl/color_bar_gen.sv */
// Post-DDR colour-bar pattern
// Word counter, eight vertical bands
`timescale 1ns/1ps

module color_bar_gen #(
	parameter int H_NUM = frame_geom_pkg::DEF_H_NUM,
	parameter int V_NUM = frame_geom_pkg::DEF_V_NUM
) (
	input  logic                     pclk_div2,
	input  logic                     core_rst_n,
	input  logic                     i_session_start,
	input  logic                     i_mwr_rd_clk_en,
	input  logic                     i_bgrx_en,
	output pixel_fmt_pkg::bus_word_t o_pattern_word
);
	import frame_geom_pkg::*;
	import pixel_fmt_pkg::*;

	localparam logic [X_CNT_W-1:0] WPL_565   = X_CNT_W'(H_NUM / 8);
	localparam logic [X_CNT_W-1:0] WPL_BGRX  = X_CNT_W'(H_NUM / 4);
	localparam int                 BAND_PIX  = H_NUM / 8;    // Pixels per bar

	logic [X_CNT_W-1:0] word_x;
	logic [X_CNT_W-1:0] words_per_line;
	logic [X_CNT_W+2:0] pix_x;
	logic [2:0]         band;
	pix565_t            bar_color;

	assign words_per_line = i_bgrx_en ? WPL_BGRX : WPL_565;
	assign pix_x = i_bgrx_en ? {1'b0, word_x, 2'b00} : {word_x, 3'b000};    // First pixel
	assign band = 3'(pix_x / BAND_PIX);

	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			word_x <= '0;
		end else if (i_session_start) begin
			word_x <= '0;
		end else if (i_mwr_rd_clk_en) begin
			if (word_x == words_per_line - 1'b1)
				word_x <= '0;
			else
				word_x <= word_x + 1'b1;
		end
	end

	always_comb begin
		case (band)
			3'd0:    bar_color = BAR_RED;
			3'd1:    bar_color = BAR_GREEN;
			3'd2:    bar_color = BAR_BLUE;
			3'd3:    bar_color = BAR_YELLOW;
			3'd4:    bar_color = BAR_CYAN;
			3'd5:    bar_color = BAR_MAGENTA;
			3'd6:    bar_color = BAR_WHITE;
			default: bar_color = BAR_BLACK;
		endcase
	end

	// Band colour of the first pixel fills the whole word
	assign o_pattern_word = i_bgrx_en ? {4{expand_565_to_bgrx(bar_color)}} : {8{bar_color}};

	a_coord_range: assert property (@(posedge pclk_div2) disable iff (!core_rst_n)
		word_x < words_per_line)
		else $error("Pattern word index beyond the end of the line");

endmodule

/* rtl/mwr_word_mux.sv */
// DMA word selection with BGRX expansion, frame word hold,
// fetch enable and stream ready gating
`timescale 1ns/1ps

module mwr_word_mux (
	input  logic                     pclk_div2,
	input  logic                     i_mwr_rd_clk_en,
	input  logic                     i_bgrx_en,
	input  logic                     i_pattern_en,
	input  logic                     i_expand_phase,
	input  logic                     i_session_active,
	input  pixel_fmt_pkg::bus_word_t i_frame_rd_data,
	input  logic                     i_frame_rd_ready,
	input  pixel_fmt_pkg::bus_word_t i_pattern_word,
	input  logic                     i_slave2_tready_raw,
	output pixel_fmt_pkg::bus_word_t o_mwr_rd_data,
	output logic                     o_frame_rd_fetch_en,
	output logic                     o_slave2_tready
);
	import pixel_fmt_pkg::*;

	bus_word_t frame_hold;    // Upper pixels wait here for phase 1
	bus_word_t bgrx_lo;
	bus_word_t bgrx_hi;
	bus_word_t frame_word;

	// In BGRX mode a new frame word is needed every other DMA word
	assign o_frame_rd_fetch_en = i_mwr_rd_clk_en & (~i_bgrx_en | ~i_expand_phase);

	always_ff @(posedge pclk_div2) begin
		if (o_frame_rd_fetch_en)
			frame_hold <= i_frame_rd_data;
	end

	assign bgrx_lo = pack_4pix_bgrx(i_frame_rd_data[15:0], i_frame_rd_data[31:16],
		i_frame_rd_data[47:32], i_frame_rd_data[63:48]);
	assign bgrx_hi = pack_4pix_bgrx(frame_hold[79:64], frame_hold[95:80],
		frame_hold[111:96], frame_hold[127:112]);

	always_comb begin
		if (!i_bgrx_en)
			frame_word = i_frame_rd_data;    // 565 pass-through
		else if (i_expand_phase)
			frame_word = bgrx_hi;
		else
			frame_word = bgrx_lo;
	end

	assign o_mwr_rd_data = i_pattern_en ? i_pattern_word : frame_word;

	// Frame buffer readiness only matters inside a session
	assign o_slave2_tready = i_slave2_tready_raw & (i_frame_rd_ready | ~i_session_active);

endmodule

/* rtl/frame_dma_source.sv */
// Frame readout source for the PCIe DMA engine
// Session tracker, colour-bar generator and word mux
`timescale 1ns/1ps

module frame_dma_source #(
	parameter int H_NUM = frame_geom_pkg::DEF_H_NUM,    // Multiple of 32
	parameter int V_NUM = frame_geom_pkg::DEF_V_NUM
) (
	input  logic                     pclk_div2,
	input  logic                     core_rst_n,
	// DMA engine
	input  logic                     i_mwr_cmd_start,
	input  logic                     i_frame_done,
	input  logic                     i_mwr_rd_clk_en,
	output pixel_fmt_pkg::bus_word_t o_mwr_rd_data,
	// Frame buffer
	input  pixel_fmt_pkg::bus_word_t i_frame_rd_data,
	input  logic                     i_frame_rd_ready,
	output logic                     o_frame_rd_fetch_en,
	output logic                     o_rd_fsync,
	// PCIe core
	input  logic                     i_slave2_tready_raw,
	input  logic                     i_msi_en,
	input  logic                     i_msi_grant,
	output logic                     o_slave2_tready,
	output logic                     o_msi_req,
	// Format select, static during a session
	input  logic                     i_bgrx_en,
	input  logic                     i_pattern_en
);
	import pixel_fmt_pkg::*;

	logic      session_active;
	logic      session_start;
	logic      expand_phase;
	bus_word_t pattern_word;

	// ==================================================
	// Session control
	// ==================================================
	dma_frame_session #(
		.H_NUM (H_NUM),
		.V_NUM (V_NUM)
	) session_i (
		.pclk_div2        (pclk_div2),
		.core_rst_n       (core_rst_n),
		.i_mwr_cmd_start  (i_mwr_cmd_start),
		.i_frame_done     (i_frame_done),
		.i_mwr_rd_clk_en  (i_mwr_rd_clk_en),
		.i_bgrx_en        (i_bgrx_en),
		.i_msi_en         (i_msi_en),
		.i_msi_grant      (i_msi_grant),
		.o_session_active (session_active),
		.o_session_start  (session_start),
		.o_expand_phase   (expand_phase),
		.o_rd_fsync       (o_rd_fsync),
		.o_msi_req        (o_msi_req)
	);

	// ==================================================
	// Data path
	// ==================================================
	color_bar_gen #(
		.H_NUM (H_NUM),
		.V_NUM (V_NUM)
	) bars_i (
		.pclk_div2       (pclk_div2),
		.core_rst_n      (core_rst_n),
		.i_session_start (session_start),
		.i_mwr_rd_clk_en (i_mwr_rd_clk_en),
		.i_bgrx_en       (i_bgrx_en),
		.o_pattern_word  (pattern_word)
	);

	mwr_word_mux mux_i (
		.pclk_div2           (pclk_div2),
		.i_mwr_rd_clk_en     (i_mwr_rd_clk_en),
		.i_bgrx_en           (i_bgrx_en),
		.i_pattern_en        (i_pattern_en),
		.i_expand_phase      (expand_phase),
		.i_session_active    (session_active),
		.i_frame_rd_data     (i_frame_rd_data),
		.i_frame_rd_ready    (i_frame_rd_ready),
		.i_pattern_word      (pattern_word),
		.i_slave2_tready_raw (i_slave2_tready_raw),
		.o_mwr_rd_data       (o_mwr_rd_data),
		.o_frame_rd_fetch_en (o_frame_rd_fetch_en),
		.o_slave2_tready     (o_slave2_tready)
	);

endmodule

/* verification/frame_dma_source_tb.sv */
// Testbench for the frame DMA source
// Replays per-cycle vectors from a data file and checks every output
`timescale 1ns/1ps

module frame_dma_source_tb;
	import pixel_fmt_pkg::*;

	localparam int H_NUM        = 32;    // 8 words in 565 and 16 in BGRX
	localparam int V_NUM        = 2;
	localparam int MAX_LINES    = 200;
	localparam int MAX_CYCLES   = 2000;
	localparam int IDLE_TIMEOUT = 8;

	logic      pclk_div2;
	logic      core_rst_n;
	logic      i_mwr_cmd_start;
	logic      i_frame_done;
	logic      i_mwr_rd_clk_en;
	logic      i_bgrx_en;
	logic      i_pattern_en;
	logic      i_frame_rd_ready;
	logic      i_slave2_tready_raw;
	logic      i_msi_en;
	logic      i_msi_grant;
	bus_word_t i_frame_rd_data;
	bus_word_t o_mwr_rd_data;
	logic      o_frame_rd_fetch_en;
	logic      o_rd_fsync;
	logic      o_slave2_tready;
	logic      o_msi_req;

	frame_dma_source #(
		.H_NUM (H_NUM),
		.V_NUM (V_NUM)
	) dut_i (
		.pclk_div2           (pclk_div2),
		.core_rst_n          (core_rst_n),
		.i_mwr_cmd_start     (i_mwr_cmd_start),
		.i_frame_done        (i_frame_done),
		.i_mwr_rd_clk_en     (i_mwr_rd_clk_en),
		.o_mwr_rd_data       (o_mwr_rd_data),
		.i_frame_rd_data     (i_frame_rd_data),
		.i_frame_rd_ready    (i_frame_rd_ready),
		.o_frame_rd_fetch_en (o_frame_rd_fetch_en),
		.o_rd_fsync          (o_rd_fsync),
		.i_slave2_tready_raw (i_slave2_tready_raw),
		.i_msi_en            (i_msi_en),
		.i_msi_grant         (i_msi_grant),
		.o_slave2_tready     (o_slave2_tready),
		.o_msi_req           (o_msi_req),
		.i_bgrx_en           (i_bgrx_en),
		.i_pattern_en        (i_pattern_en)
	);

	initial begin
		pclk_div2 = 1'b0;
		forever #50 pclk_div2 = ~pclk_div2;    // 100 ns period
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic compare_value(input string name, input int line_no,
		input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s at vector line %0d: got %h, expected %h",
				name, line_no, got, exp));
	endtask

	// Input bits from the MSB down are start, done, rd_en, bgrx, pattern,
	// fb_ready, raw ready, msi_en and grant
	task automatic drive_inputs(input logic [8:0] bits, input bus_word_t data);
		@(posedge pclk_div2);
		i_mwr_cmd_start     <= bits[8];
		i_frame_done        <= bits[7];
		i_mwr_rd_clk_en     <= bits[6];
		i_bgrx_en           <= bits[5];
		i_pattern_en        <= bits[4];
		i_frame_rd_ready    <= bits[3];
		i_slave2_tready_raw <= bits[2];
		i_msi_en            <= bits[1];
		i_msi_grant         <= bits[0];
		i_frame_rd_data     <= data;
	endtask

	// Sampled mid-cycle away from the clock edge
	task automatic check_outputs(input int line_no, input bus_word_t exp_data,
		input logic [3:0] flags);
		@(negedge pclk_div2);
		compare_value("o_mwr_rd_data", line_no, o_mwr_rd_data, exp_data);
		compare_value("o_frame_rd_fetch_en", line_no, 128'(o_frame_rd_fetch_en), 128'(flags[3]));
		compare_value("o_rd_fsync", line_no, 128'(o_rd_fsync), 128'(flags[2]));
		compare_value("o_slave2_tready", line_no, 128'(o_slave2_tready), 128'(flags[1]));
		compare_value("o_msi_req", line_no, 128'(o_msi_req), 128'(flags[0]));
	endtask

	initial begin : watchdog
		int cycles;
		for (cycles = 0; cycles < MAX_CYCLES; cycles++)
			@(posedge pclk_div2);
		abort_run("Simulation did not finish within the cycle limit");
	end

	// ==================================================
	// Vector replay
	// ==================================================
	initial begin : vector_run
		int         fd;
		int         rc;
		int         line_no;
		int         reps;
		int         rep;
		int         vec_count;
		int         idle_cycles;
		string      line;
		logic [8:0] in_bits;
		bus_word_t  rd_data;
		bus_word_t  exp_data;
		logic [3:0] exp_flags;

		core_rst_n          = 1'b0;
		i_mwr_cmd_start     = 1'b0;
		i_frame_done        = 1'b0;
		i_mwr_rd_clk_en     = 1'b0;
		i_bgrx_en           = 1'b0;
		i_pattern_en        = 1'b0;
		i_frame_rd_ready    = 1'b0;
		i_slave2_tready_raw = 1'b0;
		i_msi_en            = 1'b0;
		i_msi_grant         = 1'b0;
		i_frame_rd_data     = '0;
		vec_count           = 0;

		repeat (2) @(posedge pclk_div2);
		core_rst_n <= 1'b1;
		@(negedge pclk_div2);

		// No fsync or MSI may be left over from reset
		idle_cycles = 0;
		while ((o_rd_fsync !== 1'b0 || o_msi_req !== 1'b0) && idle_cycles < IDLE_TIMEOUT) begin
			@(negedge pclk_div2);
			idle_cycles++;
		end
		if (o_rd_fsync !== 1'b0 || o_msi_req !== 1'b0)
			abort_run("DUT outputs did not settle to idle after reset");

		fd = $fopen("verification/mwr_tests.txt", "r");
		if (fd == 0)
			abort_run("Could not open verification/mwr_tests.txt");

		for (line_no = 1; line_no <= MAX_LINES && !$feof(fd); line_no++) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;    // Blank or comment
			rc = $sscanf(line, "%d %b %h %h %b", reps, in_bits, rd_data, exp_data, exp_flags);
			if (rc != 5)
				abort_run($sformatf("Vector line %0d could not be parsed", line_no));
			for (rep = 0; rep < reps; rep++) begin
				drive_inputs(in_bits, rd_data);
				check_outputs(line_no, exp_data, exp_flags);
				vec_count++;
			end
		end
		$fclose(fd);

		if (vec_count == 0) begin
			abort_run("No vectors were applied from the test file");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* frame_dma_source.f */
rtl/frame_geom_pkg.sv
rtl/pixel_fmt_pkg.sv
rtl/dma_frame_session.sv
rtl/color_bar_gen.sv
rtl/mwr_word_mux.sv
rtl/frame_dma_source.sv
verification/frame_dma_source_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the frame DMA source testbench with Verilator
TOP=frame_dma_source_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$TOP" -f frame_dma_source.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* verification/mwr_tests.txt */
# reps, inputs start/done/rd_en/bgrx/pattern/fb_ready/raw_ready/msi_en/grant, frame_rd_data
# expected mwr_rd_data, flags fetch_en/rd_fsync/slave2_tready/msi_req
# 565 pass-through, 31-cycle fsync, ignored second start, session end after 8 words
1 100000110 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 0010
1 000000110 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 0100
1 000001010 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 0100
1 101001110 00112233445566778899aabbccddeeff 00112233445566778899aabbccddeeff 1110
6 001001110 ffeeddccbbaa99887766554433221100 ffeeddccbbaa99887766554433221100 1110
1 001000110 ffeeddccbbaa99887766554433221100 ffeeddccbbaa99887766554433221100 1100
1 000000110 ffeeddccbbaa99887766554433221100 ffeeddccbbaa99887766554433221100 0110
20 000000110 ffeeddccbbaa99887766554433221100 ffeeddccbbaa99887766554433221100 0110
1 000000010 ffeeddccbbaa99887766554433221100 ffeeddccbbaa99887766554433221100 0000
# BGRX low half live, high half held, frame done and MSI grant
1 100101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0010
1 001101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 1110
1 001101110 0000f80007e0001f123484100841ffff 08a54510088482840808080808ffffff 0110
1 001101110 0000f80007e0001f123484100841ffff 08a54510088482840808080808ffffff 1110
1 001101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0110
1 010101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0110
1 000101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 000101111 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 000101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0010
# MSI masked by msi_en, frame done wins over grant
1 010101100 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0010
2 000101100 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0010
1 000101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 010101111 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 000101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 000101111 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0011
1 000101110 123484100841ffff0000f80007e0001f 08000000080000ff0800ff0008ff0000 0010
# Colour bars in BGRX, one band per word
1 100111100 00112233445566778899aabbccddeeff 0800ffff0800ffff0800ffff0800ffff 0010
1 001111100 00112233445566778899aabbccddeeff 08ff000008ff000008ff000008ff0000 1110
1 001111100 00112233445566778899aabbccddeeff 0800ff000800ff000800ff000800ff00 0110
1 001111100 00112233445566778899aabbccddeeff 080000ff080000ff080000ff080000ff 1110
1 001111100 00112233445566778899aabbccddeeff 08ffff0008ffff0008ffff0008ffff00 0110
1 001111100 00112233445566778899aabbccddeeff 0800ffff0800ffff0800ffff0800ffff 1110
1 001111100 00112233445566778899aabbccddeeff 08ff00ff08ff00ff08ff00ff08ff00ff 0110
1 001111100 00112233445566778899aabbccddeeff 08ffffff08ffffff08ffffff08ffffff 1110
1 001111100 00112233445566778899aabbccddeeff 08000000080000000800000008000000 0110
1 010111100 00112233445566778899aabbccddeeff 08ff000008ff000008ff000008ff0000 0110
# Colour bars in 565, first pixel of each word picks the band
1 100011100 00112233445566778899aabbccddeeff 001f001f001f001f001f001f001f001f 0010
1 001011100 00112233445566778899aabbccddeeff 001f001f001f001f001f001f001f001f 1110
1 001011100 00112233445566778899aabbccddeeff f800f800f800f800f800f800f800f800 1110
1 001011100 00112233445566778899aabbccddeeff ffe0ffe0ffe0ffe0ffe0ffe0ffe0ffe0 1110
1 001011100 00112233445566778899aabbccddeeff ffffffffffffffffffffffffffffffff 1110
1 000010100 00112233445566778899aabbccddeeff 001f001f001f001f001f001f001f001f 0100
